// File: hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

  typedef logic [31:0] instr_t;

  typedef enum logic [1:0] {
    MODE_REG    = 2'h0,
    MODE_REGIND = 2'h1,
    MODE_IMM    = 2'h2,
    MODE_DIR    = 2'h3
  } addr_mode_t;

  typedef logic [6:0] opcode_t; // zero-extended, position depends on mode

  typedef logic [3:0] reg_addr_t;

  typedef logic [2:0] alu_func_t; // low three opcode bits for alu ops

  localparam alu_func_t ALU_ADD = 3'h2;
  localparam alu_func_t ALU_SUB = 3'h3;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

  typedef enum logic [3:0] {
    COND_BRA  = 4'h0,
    COND_BEQ  = 4'h1,
    COND_BNE  = 4'h2,
    COND_BGTU = 4'h3,
    COND_BGT  = 4'h4,
    COND_BGE  = 4'h5,
    COND_BLE  = 4'h6,
    COND_BLT  = 4'h7,
    COND_BGEU = 4'h8,
    COND_BLTU = 4'h9,
    COND_BLEU = 4'ha,
    COND_BRN  = 4'hb
  } branch_cond_t;

  typedef enum logic [1:0] {
    SIZE_WORD = 2'h0,
    SIZE_HALF = 2'h1,
    SIZE_BYTE = 2'h2
  } access_size_t;

  typedef enum logic [3:0] {
    CLASS_NOP, CLASS_CMP, CLASS_MOV, CLASS_COM, CLASS_NEG,
    CLASS_EXTB, CLASS_EXTH, CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LDIU,
    CLASS_BRANCH, CLASS_LOAD, CLASS_STORE, CLASS_JMP, CLASS_ILLEGAL
  } instr_class_t;

  typedef struct packed {
    instr_class_t iclass;
    reg_addr_t    ra;
    reg_addr_t    rb;
    reg_addr_t    rc;
    alu_func_t    alu_func;
    branch_cond_t cond;
    access_size_t size;
  } decoded_instr_t;

endpackage

// File: hdl/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;
  import cpu_isa_pkg::*;

  typedef enum logic [2:0] {
    ST_RESET     = 3'h0,
    ST_FETCH     = 3'h1,
    ST_EXECUTE   = 3'h2,
    ST_EXCEPTION = 3'h3,
    ST_HALT      = 3'h4
  } ctrl_state_t;

  typedef logic [2:0] step_t;

  typedef enum logic [2:0] {
    PC_HOLD   = 3'h0,
    PC_INC    = 3'h1,
    PC_MAR    = 3'h2,
    PC_REL    = 3'h3, // pc plus branch displacement
    PC_ALU    = 3'h4,
    PC_VECTOR = 3'h5
  } pc_sel_t;

  typedef enum logic [3:0] {
    SRC_ALU  = 4'h0,
    SRC_MDR  = 4'h1,
    SRC_NEG  = 4'h2,
    SRC_COM  = 4'h3,
    SRC_MOV  = 4'h4,
    SRC_UIMM = 4'h6, // unsigned 16-bit immediate
    SRC_EXTB = 4'h9,
    SRC_EXTH = 4'ha
  } reg_src_t;

  typedef enum logic [2:0] {
    ALUB_REG = 3'h0,
    ALUB_IMM = 3'h1,
    ALUB_ONE = 3'h2
  } alu_b_sel_t;

  typedef enum logic [1:0] {
    MAR_HOLD = 2'h0,
    MAR_BUS  = 2'h1,
    MAR_ALU  = 2'h2
  } mar_sel_t;

  typedef enum logic [2:0] {
    MDR_HOLD = 3'h0,
    MDR_BUS  = 3'h1,
    MDR_RA   = 3'h3
  } mdr_sel_t;

  typedef struct packed {
    logic       ir_write;
    logic       ccr_write;
    logic       reg_write;
    alu_func_t  alu_func;
    alu_b_sel_t alu_b_sel;
    reg_src_t   reg_src;
    reg_addr_t  read_addr1;
    reg_addr_t  read_addr2;
    reg_addr_t  write_addr;
    mar_sel_t   mar_sel;
    mdr_sel_t   mdr_sel;
    pc_sel_t    pc_sel;
  } control_word_t;

  typedef struct packed {
    logic       bus_read;
    logic       bus_write;
    logic       addr_from_mar; // address bus from mar instead of pc
    logic [3:0] byteenable;
  } bus_request_t;

endpackage

// File: hdl/ir_decoder.sv
`timescale 1ns/1ps

module ir_decoder
  import cpu_isa_pkg::*;
(
  input  instr_t         ir,
  output decoded_instr_t dec
);

  addr_mode_t   mode;
  opcode_t      opcode;
  instr_class_t iclass;
  alu_func_t    alu_func;
  access_size_t size;

  assign mode = addr_mode_t'(ir[31:30]);

  // opcode field sits at a different place in each mode
  always_comb begin
    case (mode)
      MODE_REG:    opcode = ir[29:23];
      MODE_REGIND: opcode = {3'b000, ir[29:26]};
      MODE_IMM:    opcode = {3'b000, ir[29:26]};
      default:     opcode = {1'b0, ir[29:24]};
    endcase
  end

  always_comb begin
    iclass = CLASS_ILLEGAL;
    case (mode)
      MODE_REG: begin
        case (opcode) inside
          7'h00:          iclass = CLASS_NOP;
          7'h09:          iclass = CLASS_CMP;
          7'h0a:          iclass = CLASS_MOV;
          7'h0b:          iclass = CLASS_COM;
          7'h0c:          iclass = CLASS_NEG;
          7'h12:          iclass = CLASS_EXTB;
          7'h13:          iclass = CLASS_EXTH;
          [7'h20:7'h2f]:  iclass = CLASS_ALU_REG; // rA <= rB op rC
          default:        iclass = CLASS_ILLEGAL;
        endcase
      end
      MODE_REGIND: begin
        case (opcode) inside
          [7'h00:7'h05]:  iclass = opcode[0] ? CLASS_LOAD : CLASS_STORE;
          7'h09:          iclass = CLASS_JMP;
          default:        iclass = CLASS_ILLEGAL;
        endcase
      end
      MODE_IMM: begin
        case (opcode) inside
          [7'h00:7'h0b]:  iclass = CLASS_BRANCH;
          7'h0c:          iclass = CLASS_LDIU;
          default:        iclass = CLASS_ILLEGAL;
        endcase
      end
      default: begin
        if (opcode[6:4] == 3'h0)
          iclass = CLASS_ALU_IMM; // rA <= rB op immediate
      end
    endcase
  end

  always_comb begin
    case (iclass)
      CLASS_ALU_REG, CLASS_ALU_IMM: alu_func = opcode[2:0];
      CLASS_CMP:                    alu_func = ALU_SUB;
      default:                      alu_func = ALU_ADD; // address arithmetic
    endcase
  end

  // pairs of st/ld per size
  always_comb begin
    case (opcode[2:1])
      2'h0:    size = SIZE_WORD;
      2'h1:    size = SIZE_HALF;
      default: size = SIZE_BYTE;
    endcase
  end

  always_comb begin
    dec.iclass   = iclass;
    dec.ra       = ir[19:16];
    dec.rb       = ir[15:12];
    dec.rc       = ir[11:8];
    dec.alu_func = alu_func;
    dec.cond     = branch_cond_t'(opcode[3:0]);
    dec.size     = size;
  end

endmodule

// File: hdl/branch_condition.sv
`timescale 1ns/1ps

module branch_condition
  import cpu_isa_pkg::*;
(
  input  branch_cond_t cond,
  input  ccr_t         ccr,
  output logic         taken
);

  logic n_ne_v;

  assign n_ne_v = ccr.negative ^ ccr.overflow; // signed less-than

  always_comb begin
    case (cond)
      COND_BRA:  taken = 1'b1;
      COND_BEQ:  taken = ccr.zero;
      COND_BNE:  taken = ~ccr.zero;
      COND_BGTU: taken = ~(ccr.zero | ccr.carry);
      COND_BGT:  taken = ~(ccr.zero | n_ne_v);
      COND_BGE:  taken = ~n_ne_v;
      COND_BLE:  taken = ccr.zero | n_ne_v;
      COND_BLT:  taken = n_ne_v;
      COND_BGEU: taken = ~ccr.carry;
      COND_BLTU: taken = ccr.carry;
      COND_BLEU: taken = ccr.carry | ccr.zero;
      default:   taken = 1'b0; // brn
    endcase
  end

endmodule

// File: hdl/control_sequencer.sv
`timescale 1ns/1ps

module control_sequencer
  import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
  input  logic           clock,
  input  logic           reset_n,
  input  decoded_instr_t dec,
  input  logic           taken,
  input  logic           bus_wait,
  input  logic           busfault,
  input  logic [1:0]     bus_align,
  output control_word_t  ctrl,
  output bus_request_t   bus,
  output logic           halt
);

  ctrl_state_t state, state_next;
  step_t       step, step_next;
  logic [3:0]  sized_lanes;

  // lane enables for a sized data access
  always_comb begin
    case (dec.size)
      SIZE_WORD: sized_lanes = 4'b1111;
      SIZE_HALF: sized_lanes = bus_align[1] ? 4'b0011 : 4'b1100;
      default:   sized_lanes = 4'b1000 >> bus_align;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_RESET;
      step  <= '0;
    end else begin
      state <= state_next;
      step  <= step_next;
    end
  end

  assign halt = (state == ST_HALT);

  always_comb begin
    state_next          = state;
    step_next           = step;
    ctrl.ir_write       = 1'b0;
    ctrl.ccr_write      = 1'b0;
    ctrl.reg_write      = 1'b0;
    ctrl.alu_func       = ALU_ADD;
    ctrl.alu_b_sel      = ALUB_REG;
    ctrl.reg_src        = SRC_ALU;
    ctrl.read_addr1     = dec.ra;
    ctrl.read_addr2     = dec.rb;
    ctrl.write_addr     = dec.ra;
    ctrl.mar_sel        = MAR_HOLD;
    ctrl.mdr_sel        = MDR_HOLD;
    ctrl.pc_sel         = PC_HOLD;
    bus.bus_read        = 1'b0;
    bus.bus_write       = 1'b0;
    bus.addr_from_mar   = 1'b0; // pc drives the address bus
    bus.byteenable      = 4'b1111;

    case (state)
      ST_RESET: begin
        case (step)
          3'h0: begin
            ctrl.pc_sel  = PC_VECTOR;
            bus.bus_read = 1'b1; // read the reset vector
            if (busfault)
              state_next = ST_EXCEPTION;
            else if (!bus_wait)
              step_next = 3'h1;
          end
          3'h1: begin
            bus.bus_read = 1'b1;
            ctrl.mar_sel = MAR_BUS;
            step_next    = 3'h2;
          end
          3'h2: begin
            ctrl.pc_sel = PC_MAR;
            state_next  = ST_FETCH;
            step_next   = '0;
          end
          default: state_next = ST_HALT;
        endcase
      end

      ST_FETCH: begin
        case (step)
          3'h0: begin
            bus.bus_read = 1'b1;
            if (busfault)
              state_next = ST_EXCEPTION;
            else if (!bus_wait) // bus granted
              step_next = 3'h1;
          end
          3'h1: begin
            bus.bus_read  = 1'b1; // keep data on the bus
            ctrl.ir_write = 1'b1;
            step_next     = 3'h2;
          end
          3'h2: begin
            ctrl.pc_sel = PC_INC;
            state_next  = ST_EXECUTE;
            step_next   = '0;
          end
          default: state_next = ST_HALT;
        endcase
      end

      ST_EXECUTE: begin
        // single-cycle classes return to fetch unless overridden below
        state_next = ST_FETCH;
        step_next  = '0;
        case (dec.iclass)
          CLASS_NOP: ;
          CLASS_CMP: begin
            ctrl.alu_func  = dec.alu_func; // ra - rb
            ctrl.ccr_write = 1'b1;
          end
          CLASS_MOV, CLASS_COM, CLASS_NEG, CLASS_EXTB, CLASS_EXTH, CLASS_LDIU: begin
            ctrl.reg_write = 1'b1;
            case (dec.iclass)
              CLASS_MOV:  ctrl.reg_src = SRC_MOV;
              CLASS_COM:  ctrl.reg_src = SRC_COM;
              CLASS_NEG:  ctrl.reg_src = SRC_NEG;
              CLASS_EXTB: ctrl.reg_src = SRC_EXTB;
              CLASS_EXTH: ctrl.reg_src = SRC_EXTH;
              default:    ctrl.reg_src = SRC_UIMM;
            endcase
          end
          CLASS_BRANCH: begin
            if (taken)
              ctrl.pc_sel = PC_REL;
          end
          CLASS_ALU_REG, CLASS_ALU_IMM: begin
            ctrl.alu_func   = dec.alu_func;
            ctrl.read_addr1 = dec.rb;
            ctrl.read_addr2 = dec.rc;
            if (dec.iclass == CLASS_ALU_IMM)
              ctrl.alu_b_sel = ALUB_IMM;
            if (step == 3'h0) begin
              state_next = ST_EXECUTE; // let the alu result settle
              step_next  = 3'h1;
            end else begin
              ctrl.reg_write = 1'b1;
            end
          end
          CLASS_JMP: begin
            ctrl.read_addr1 = dec.rb;
            ctrl.alu_b_sel  = ALUB_IMM; // rB + displacement
            if (step == 3'h0) begin
              state_next = ST_EXECUTE;
              step_next  = 3'h1;
            end else begin
              ctrl.pc_sel = PC_ALU;
            end
          end
          CLASS_LOAD, CLASS_STORE: begin
            bus.addr_from_mar = 1'b1;
            state_next        = ST_EXECUTE;
            case (step)
              3'h0: begin
                ctrl.read_addr1 = dec.rb;
                ctrl.alu_b_sel  = ALUB_IMM; // effective address
                step_next       = 3'h1;
              end
              3'h1: begin
                ctrl.mar_sel = MAR_ALU;
                if (dec.iclass == CLASS_STORE)
                  ctrl.mdr_sel = MDR_RA;
                step_next = 3'h2;
              end
              3'h2: begin
                bus.byteenable = sized_lanes;
                if (dec.iclass == CLASS_LOAD) begin
                  bus.bus_read = 1'b1;
                  ctrl.mdr_sel = MDR_BUS;
                end else begin
                  bus.bus_write = 1'b1;
                end
                if (busfault)
                  state_next = ST_EXCEPTION;
                else if (!bus_wait)
                  step_next = 3'h3;
              end
              3'h3: begin
                if (dec.iclass == CLASS_LOAD) begin
                  ctrl.reg_src   = SRC_MDR;
                  ctrl.reg_write = 1'b1;
                end
                state_next = ST_FETCH;
                step_next  = '0;
              end
              default: state_next = ST_HALT;
            endcase
          end
          default: state_next = ST_HALT; // undefined opcode
        endcase
      end

      ST_EXCEPTION: begin
        state_next = ST_HALT; // one cycle, no handler
        step_next  = '0;
      end

      default: state_next = ST_HALT;
    endcase
  end

endmodule

// File: hdl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control
  import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
  input  logic          clock,
  input  logic          reset_n,
  input  instr_t        ir,
  input  ccr_t          ccr,
  input  logic          bus_wait,
  input  logic          busfault,
  input  logic [1:0]    bus_align,
  output control_word_t ctrl,
  output bus_request_t  bus,
  output logic          halt
);

  decoded_instr_t dec;
  logic           taken;

  ir_decoder u_ir_decoder (
    .ir  (ir),
    .dec (dec)
  );

  // only meaningful while dec.iclass is a branch
  branch_condition u_branch_condition (
    .cond  (dec.cond),
    .ccr   (ccr),
    .taken (taken)
  );

  control_sequencer u_control_sequencer (
    .clock     (clock),
    .reset_n   (reset_n),
    .dec       (dec),
    .taken     (taken),
    .bus_wait  (bus_wait),
    .busfault  (busfault),
    .bus_align (bus_align),
    .ctrl      (ctrl),
    .bus       (bus),
    .halt      (halt)
  );

endmodule

// File: tb/cpu_control_checks.svh
`ifndef CPU_CONTROL_CHECKS_SVH
`define CPU_CONTROL_CHECKS_SVH

int    checks_passed   = 0;
int    checks_failed   = 0;
int    failed_at_start = 0; // failures before the running test
string cur_test        = "";

task automatic start_test(input string name);
  cur_test        = name;
  failed_at_start = checks_failed;
endtask

task automatic finish_test();
  if (checks_failed == failed_at_start)
    $display("test %s: ok", cur_test);
  else
    $display("test %s: %0d checks failed", cur_test, checks_failed - failed_at_start);
endtask

// only the fields set in mask take part
task automatic check_control_word(input string what, input control_word_t exp,
                                  input control_word_t act, input control_word_t mask);
  if ((exp & mask) === (act & mask)) begin
    checks_passed++;
  end else begin
    checks_failed++;
    $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp & mask, act & mask);
  end
endtask

task automatic check_bus_request(input string what, input bus_request_t exp,
                                 input bus_request_t act);
  if (exp === act) begin
    checks_passed++;
  end else begin
    checks_failed++;
    $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  if (exp === act) begin
    checks_passed++;
  end else begin
    checks_failed++;
    $display("FAILED %s: %s expected %b actual %b", cur_test, what, exp, act);
  end
endtask

`endif

// File: tb/cpu_control_tb.sv
`timescale 1ns/1ps

module cpu_control_tb
  import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int RUN_CYCLES = 8; // fetch plus the longest execute, with margin
  localparam int N_RUNS     = 1 + 24 + 12 * 16 + 25 + 2;
  localparam int BUDGET     = N_RUNS * RUN_CYCLES + 4 * 40; // resets and halt checks
  localparam logic [3:0] BYTE_LANES [4] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001};

  logic          clock;
  logic          reset_n;
  instr_t        ir;
  ccr_t          ccr;
  logic          bus_wait;
  logic          busfault;
  logic [1:0]    bus_align;
  control_word_t ctrl;
  bus_request_t  bus;
  logic          halt;

  instr_t        next_instr;
  ccr_t          next_ccr;
  logic [1:0]    next_align;
  control_word_t cw_log[$]; // one entry per cycle after the increment step
  bus_request_t  br_log[$];

  `include "cpu_control_checks.svh"

  cpu_control dut0 (
    .clock     (clock),
    .reset_n   (reset_n),
    .ir        (ir),
    .ccr       (ccr),
    .bus_wait  (bus_wait),
    .busfault  (busfault),
    .bus_align (bus_align),
    .ctrl      (ctrl),
    .bus       (bus),
    .halt      (halt)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // instruction memory, flags and alignment travel with the fetched word
  always @(posedge clock) begin
    if (ctrl.ir_write) begin
      ir        <= next_instr;
      ccr       <= next_ccr;
      bus_align <= next_align;
    end
  end

  function automatic instr_t encode(input addr_mode_t mode, input logic [6:0] op,
                                    input reg_addr_t ra, input reg_addr_t rb,
                                    input reg_addr_t rc);
    logic [7:0] low;
    low = 8'($urandom);
    case (mode)
      MODE_REG: return {mode, op, 3'b000, ra, rb, rc, low};
      MODE_DIR: return {mode, op[5:0], 4'h0, ra, rb, rc, low};
      default:  return {mode, op[3:0], 6'h00, ra, rb, rc, low};
    endcase
  endfunction

  function automatic control_word_t select_fields(input bit strobes, input bit dest,
                                                  input bit pc, input bit alu,
                                                  input bit mem);
    control_word_t m;
    m = '0;
    if (strobes) begin
      m.ir_write  = 1'b1;
      m.ccr_write = 1'b1;
      m.reg_write = 1'b1;
    end
    if (dest) begin
      m.reg_src    = reg_src_t'(4'hf);
      m.write_addr = 4'hf;
    end
    if (pc)
      m.pc_sel = pc_sel_t'(3'h7);
    if (alu) begin
      m.alu_func   = 3'h7;
      m.alu_b_sel  = alu_b_sel_t'(3'h7);
      m.read_addr1 = 4'hf;
      m.read_addr2 = 4'hf;
    end
    if (mem) begin
      m.mar_sel = mar_sel_t'(2'h3);
      m.mdr_sel = mdr_sel_t'(3'h7);
    end
    return m;
  endfunction

  function automatic logic branch_rule(input int cond, input ccr_t f);
    logic lt;
    lt = f.negative != f.overflow;
    case (cond)
      0:       return 1'b1;
      1:       return f.zero;
      2:       return !f.zero;
      3:       return !f.zero && !f.carry;
      4:       return !f.zero && !lt;
      5:       return !lt;
      6:       return f.zero || lt;
      7:       return lt;
      8:       return !f.carry;
      9:       return f.carry;
      10:      return f.carry || f.zero;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [3:0] lane_rule(input int size, input logic [1:0] align);
    if (size == 0)
      return 4'b1111;
    if (size == 1)
      return align[1] ? 4'b0011 : 4'b1100;
    return BYTE_LANES[align];
  endfunction

  function automatic int reg_writes();
    int n;
    n = 0;
    foreach (cw_log[i])
      n += cw_log[i].reg_write;
    return n;
  endfunction

  task automatic apply_reset(input logic wait_high);
    @(posedge clock);
    reset_n  <= 1'b0;
    bus_wait <= wait_high;
    busfault <= 1'b0;
    repeat (8) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
  endtask

  // fetches one word and logs every cycle until the next ir_write or halt
  task automatic run_instr(input instr_t instr, input ccr_t flags, input logic [1:0] align);
    control_word_t inc;
    int n;
    next_instr = instr;
    next_ccr   = flags;
    next_align = align;
    inc        = '0;
    inc.pc_sel = PC_INC;
    n          = 0;
    while (!ctrl.ir_write && !halt && n < 20) begin
      @(negedge clock);
      n++;
    end
    check_bit("ir_write during fetch", 1'b1, ctrl.ir_write);
    @(negedge clock);
    check_control_word("increment after ir_write", inc, ctrl, select_fields(1, 0, 1, 0, 0));
    cw_log.delete();
    br_log.delete();
    n = 0;
    @(negedge clock);
    while (!ctrl.ir_write && !halt && n < 20) begin
      cw_log.push_back(ctrl);
      br_log.push_back(bus);
      @(negedge clock);
      n++;
    end
  endtask

  task automatic expect_halted(input string what);
    int n;
    n = 0;
    while (!halt && n < 10) begin
      @(negedge clock);
      n++;
    end
    check_bit({what, ", halt"}, 1'b1, halt);
    repeat (6) begin
      @(negedge clock);
      check_bit({what, ", halt held"}, 1'b1, halt);
      check_bit({what, ", no bus strobe"}, 1'b0, bus.bus_read | bus.bus_write);
    end
  endtask

  task automatic test_reset_fetch();
    control_word_t exp;
    int hold;
    exp        = '0;
    exp.pc_sel = PC_VECTOR;
    hold       = 2 + $urandom % 6;
    start_test("reset_fetch");
    apply_reset(1'b1);
    repeat (hold) begin // vector read stalled, no ir_write allowed
      check_control_word("reset step 0", exp, ctrl, select_fields(1, 0, 1, 0, 0));
      check_bit("bus_read in reset", 1'b1, bus.bus_read);
      check_bit("bus_write in reset", 1'b0, bus.bus_write);
      @(negedge clock);
    end
    @(posedge clock);
    bus_wait <= 1'b0;
    @(negedge clock);
    run_instr(encode(MODE_REG, 7'h00, 4'h0, 4'h0, 4'h0), '0, 2'd0);
    check_bit("nop execute length", 1'b1, cw_log.size() == 2);
    finish_test();
  endtask

  task automatic test_alu_ops();
    control_word_t exp;
    reg_addr_t     ra;
    reg_addr_t     rb;
    reg_addr_t     rc;
    logic [6:0]    op;
    logic          imm;
    logic [6:0]    single_op [8] = '{7'h00, 7'h09, 7'h0a, 7'h0b, 7'h0c, 7'h12, 7'h13, 7'h0c};
    reg_src_t      single_src [8] = '{SRC_ALU, SRC_ALU, SRC_MOV, SRC_COM,
                                      SRC_NEG, SRC_EXTB, SRC_EXTH, SRC_UIMM};
    start_test("alu_ops");
    for (int i = 0; i < 16; i++) begin
      imm = i[0];
      ra  = 4'($urandom);
      rb  = 4'($urandom);
      rc  = 4'($urandom);
      op  = imm ? 7'($urandom % 16) : 7'h20 + 7'($urandom % 16);
      run_instr(encode(imm ? MODE_DIR : MODE_REG, op, ra, rb, rc), '0, 2'd0);
      exp            = '0;
      exp.alu_func   = op[2:0];
      exp.alu_b_sel  = imm ? ALUB_IMM : ALUB_REG;
      exp.read_addr1 = rb;
      exp.read_addr2 = rc;
      exp.write_addr = ra;
      exp.reg_src    = SRC_ALU;
      check_bit("alu execute length", 1'b1, cw_log.size() == 3);
      check_control_word("alu first cycle", exp, cw_log[0], select_fields(1, 0, 0, 1, 0));
      exp.reg_write = 1'b1; // result written in the last cycle
      check_control_word("alu last cycle", exp, cw_log[1], select_fields(1, 1, 0, 1, 0));
      check_bit("alu single reg_write", 1'b1, reg_writes() == 1);
    end
    for (int k = 0; k < 8; k++) begin
      ra = 4'($urandom);
      run_instr(encode(k == 7 ? MODE_IMM : MODE_REG, single_op[k], ra, 4'h3, 4'h5), '0, 2'd0);
      exp            = '0;
      exp.ccr_write  = (k == 1);
      exp.reg_write  = (k >= 2);
      exp.reg_src    = single_src[k];
      exp.write_addr = ra;
      check_bit("single execute length", 1'b1, cw_log.size() == 2);
      check_control_word($sformatf("single op %h", single_op[k]), exp, cw_log[0],
                         select_fields(1, k >= 2, 0, 0, 0));
    end
    finish_test();
  endtask

  task automatic test_branches();
    control_word_t exp;
    start_test("branches");
    for (int c = 0; c < 12; c++) begin
      for (int f = 0; f < 16; f++) begin
        run_instr(encode(MODE_IMM, 7'(c), 4'h0, 4'h0, 4'h0), ccr_t'(4'(f)), 2'd0);
        exp        = '0;
        exp.pc_sel = branch_rule(c, ccr_t'(4'(f))) ? PC_REL : PC_HOLD;
        check_control_word($sformatf("cond %0d ccr %h", c, f), exp, cw_log[0],
                           select_fields(1, 0, 1, 0, 0));
      end
    end
    finish_test();
  endtask

  task automatic test_memory();
    control_word_t exp;
    bus_request_t  data;
    bus_request_t  fetch;
    reg_addr_t     ra;
    logic          load;
    start_test("load_store_jmp");
    fetch            = '0;
    fetch.bus_read   = 1'b1;
    fetch.byteenable = 4'hf; // instruction fetch uses all lanes
    for (int op = 0; op < 6; op++) begin
      for (int a = 0; a < 4; a++) begin
        load = op[0];
        ra   = 4'($urandom);
        run_instr(encode(MODE_REGIND, 7'(op), ra, 4'h2, 4'h0), '0, 2'(a));
        data               = '0;
        data.bus_read      = load;
        data.bus_write     = !load;
        data.addr_from_mar = 1'b1;
        data.byteenable    = lane_rule(op / 2, 2'(a));
        check_bit("memory execute length", 1'b1, cw_log.size() == 5);
        for (int i = 0; i < br_log.size(); i++) begin
          if (i == 2) begin
            check_bus_request($sformatf("op %0d align %0d", op, a), data, br_log[i]);
          end else if (br_log[i].bus_read || br_log[i].bus_write) begin
            check_bus_request("fetch access", fetch, br_log[i]);
          end
        end
        exp         = '0;
        exp.mar_sel = MAR_ALU;
        exp.mdr_sel = load ? MDR_HOLD : MDR_RA; // store data staged from ra
        check_control_word("memory address cycle", exp, cw_log[1],
                           select_fields(1, 0, 0, 0, 1));
        exp         = '0;
        exp.mdr_sel = load ? MDR_BUS : MDR_HOLD;
        check_control_word("memory bus cycle", exp, cw_log[2], select_fields(1, 0, 0, 0, 1));
        exp            = '0;
        exp.reg_write  = load;
        exp.reg_src    = SRC_MDR;
        exp.write_addr = ra;
        check_control_word("memory last cycle", exp, cw_log[3],
                           select_fields(1, load, 0, 0, 0));
        check_bit("reg_write count", 1'b1, reg_writes() == int'(load));
      end
    end
    run_instr(encode(MODE_REGIND, 7'h09, 4'h1, 4'h4, 4'h0), '0, 2'd0);
    exp        = '0;
    exp.pc_sel = PC_ALU;
    check_bit("jmp execute length", 1'b1, cw_log.size() == 3);
    check_control_word("jmp target", exp, cw_log[1], select_fields(1, 0, 1, 0, 0));
    finish_test();
  endtask

  task automatic test_faults();
    int n;
    start_test("faults");
    apply_reset(1'b0);
    run_instr(encode(MODE_REG, 7'h00, 4'h0, 4'h0, 4'h0), '0, 2'd0);
    @(posedge clock);
    bus_wait <= 1'b1; // stall the next fetch in its bus step
    n = 0;
    @(negedge clock);
    while (!(bus.bus_read && !bus.addr_from_mar && !ctrl.ir_write) && n < 20) begin
      @(negedge clock);
      n++;
    end
    @(posedge clock);
    busfault <= 1'b1;
    @(negedge clock);
    expect_halted("busfault in fetch");
    @(posedge clock);
    busfault <= 1'b0;
    bus_wait <= 1'b0;
    apply_reset(1'b0);
    run_instr(encode(MODE_REG, 7'h01, 4'h0, 4'h0, 4'h0), '0, 2'd0);
    expect_halted("illegal opcode");
    finish_test();
  endtask

  initial begin
    void'($urandom(32'h135d_35a4));
    clock      = 1'b0;
    reset_n    = 1'b0;
    ir         = '0;
    ccr        = '0;
    bus_wait   = 1'b0;
    busfault   = 1'b0;
    bus_align  = 2'd0;
    next_instr = '0;
    next_ccr   = '0;
    next_align = 2'd0;
    test_reset_fetch();
    test_alu_ops();
    test_branches();
    test_memory();
    test_faults();
    $display("checks passed %0d, failed %0d", checks_passed, checks_failed);
    if (checks_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(BUDGET * 2 * CLK_PERIOD);
    $display("watchdog: simulation ran past its cycle budget");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+tb
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/ir_decoder.sv
hdl/branch_condition.sv
hdl/control_sequencer.sv
hdl/cpu_control.sv
tb/cpu_control_tb.sv
